// ==== mips_tail.f ====
+incdir+source
source/mips_tail_pkg.sv
source/pipe_ctrl.sv
source/data_sram.sv
source/mem_stage.sv
source/wb_stage.sv
source/reg_file.sv
source/mips_tail.sv
tb/mips_tail_checker.sv
tb/mips_tail_tb.sv

// ==== Makefile ====
# Verilator build and run for the mips_tail testbench

VERILATOR  ?= verilator
TOP        ?= mips_tail_tb
RTL_TOP    ?= mips_tail
FLIST      ?= mips_tail.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/mips_tail_tb.sv ====
`include "mips_tail_defines.svh"

module mips_tail_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mips_tail_pkg::*;

    localparam int n_instr     = 4000;
    localparam int clk_half    = 20;                      // 40 ns period
    localparam int drive_delay = 2;
    localparam int watchdog_ns = n_instr * 8 * 2 * clk_half;
    localparam int sram_words  = 1 << `MT_SRAM_AW;

    logic        clk;
    logic        reset;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms_bus;
    logic        commit_hold;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic        ms_allowin;
    logic        commit_valid;
    commit_t     commit;
    fwd_t        ms_fwd;
    fwd_t        ws_fwd;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;

    logic [31:0] lfsr;
    logic [31:0] smem [0:sram_words-1]; // shadow data memory
    logic [31:0] srf [0:31];            // shadow gprs
    commit_t     exp_q [$];             // accepted, not yet retired
    logic        m_ms;                  // model occupancy of ms / ws
    logic        m_ws;
    logic        accepted;              // bus taken at the last edge
    int          n_issued;
    int          n_retired;
    logic [31:0] next_pc;

    mips_tail i_mips_tail (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .commit_hold    (commit_hold),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .ms_allowin     (ms_allowin),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // access width in bytes
    function automatic int size_of(input mem_op_t op);
        case (op)
            mem_lh, mem_lhu, mem_sh: return 2;
            mem_lw, mem_sw:          return 4;
            default:                 return 1;
        endcase
    endfunction

    // expected retirement of one accepted instruction, stores land in smem now
    function automatic commit_t model_accept(input es_to_ms_t b);
        commit_t                c;
        logic                   is_ld;
        logic                   is_st;
        logic                   bad;
        logic                   ex;
        logic [1:0]             lo;
        logic [`MT_SRAM_AW-1:0] wa;
        logic [31:0]            sh;
        logic [31:0]            res;
        int                     n;
        n     = size_of(b.op);
        lo    = b.alu_result[1:0];
        wa    = b.alu_result[`MT_SRAM_AW+1:2];
        is_ld = b.op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
        is_st = b.op inside {mem_sb, mem_sh, mem_sw};
        bad   = (is_ld || is_st) && ((int'(lo) % n) != 0); // natural alignment
        ex    = b.ex || bad;
        sh    = smem[wa] >> {lo, 3'b000};
        res   = b.alu_result;
        if (is_ld && !ex) begin
            case (b.op)
                mem_lb:  res = {{24{sh[7]}}, sh[7:0]};
                mem_lbu: res = {24'b0, sh[7:0]};
                mem_lh:  res = {{16{sh[15]}}, sh[15:0]};
                mem_lhu: res = {16'b0, sh[15:0]};
                default: res = sh;
            endcase
        end
        if (is_st && !ex) begin
            for (int i = 0; i < n; i++) begin
                smem[wa][8*(int'(lo)+i) +: 8] = b.store_data[8*i +: 8];
            end
        end
        c.pc       = b.pc;
        c.rf_wen   = {4{b.gr_we && !ex}};
        c.rf_wnum  = b.dest;
        c.rf_wdata = res;
        c.ex       = ex;
        c.excode   = b.excode;                  // upstream code passes through
        if (!b.ex && bad) begin
            c.excode = is_ld ? `MT_EXC_ADEL : `MT_EXC_ADES;
        end
        return c;
    endfunction

    // bypass seen by decode for a stage holding c
    function automatic fwd_t fwd_of(input logic full, input commit_t c);
        fwd_t f;
        f.dest   = (full && c.rf_wen[0]) ? c.rf_wnum : 5'd0;
        f.result = c.rf_wdata;
        return f;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_commit(input string name, input commit_t act, input commit_t exp);
        commit_t got;
        commit_t want;
        got  = act;
        want = exp;
        if (exp.ex) begin
            got.rf_wdata  = '0; // faulting result is not architectural
            want.rf_wdata = '0;
        end
        if (got !== want) begin
            stop_with_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h",
                                      name, act, exp));
        end
    endtask

    task automatic check_fwd(input string name, input fwd_t act, input fwd_t exp);
        if ((act.dest !== exp.dest) || ((exp.dest != 5'd0) && (act.result !== exp.result))) begin
            stop_with_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h",
                                      name, act, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h",
                                      name, act, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h",
                                      name, act, exp));
        end
    endtask

    task automatic new_instr();
        es_to_ms_t   b;
        logic [31:0] r;
        logic [1:0]  off;
        logic [3:0]  w;
        int          n;
        b            = '0;
        b.pc         = next_pc;
        next_pc      = next_pc + 32'd4;
        r            = rand_bits(4) % 32'd9;
        b.op         = mem_op_t'(r[3:0]);
        r            = rand_bits(5);
        b.dest       = r[4:0];
        b.store_data = rand_bits(32);
        r            = rand_bits(4);
        w            = r[3:0];                  // word in a 16-word window
        r            = rand_bits(2);
        off          = r[1:0];
        n            = size_of(b.op);
        r            = rand_bits(3);
        if (r != 32'd0) begin
            off = off & ~2'(n - 1);             // aligned 7 times in 8
        end
        b.alu_result = 32'h0000_0100 + {26'b0, w, off};
        if (b.op == mem_none) begin
            b.alu_result = rand_bits(32);
            r            = rand_bits(1);
            b.gr_we      = r[0];
        end else begin
            b.gr_we = !(b.op inside {mem_sb, mem_sh, mem_sw});
        end
        r = rand_bits(4);
        if (r == 32'd0) begin
            b.ex     = 1'b1;                    // upstream fault, 1 in 16
            r        = rand_bits(5);
            b.excode = r[4:0];
        end
        es_to_ms_bus = b;
    endtask

    // called just after each rising edge
    task automatic drive_cycle();
        logic [31:0] r;
        r           = rand_bits(2);
        commit_hold = (r == 32'd0);
        if (!es_to_ms_valid || accepted) begin
            r = rand_bits(2);
            if ((r != 32'd0) && (n_issued < n_instr)) begin
                new_instr();
                es_to_ms_valid = 1'b1;
                n_issued++;
            end else begin
                es_to_ms_valid = 1'b0;
            end
        end
    endtask

    // sampled mid-cycle, then the model steps over the coming edge
    task automatic monitor_cycle();
        commit_t exp;
        commit_t ws_ent;
        commit_t ms_ent;
        logic    ws_allow;
        logic    ms_allow;
        logic    accept;
        ws_ent = '0;
        ms_ent = '0;
        if (m_ws) begin
            ws_ent = exp_q[0];
        end
        if (m_ms) begin
            ms_ent = exp_q[m_ws ? 1 : 0];
        end
        ws_allow = !m_ws || !commit_hold;
        ms_allow = !m_ms || ws_allow;
        accept   = es_to_ms_valid && ms_allow && !reset;
        check_flag("ms_allowin", ms_allowin, ms_allow);
        check_flag("commit_valid", commit_valid, m_ws && !commit_hold);
        check_fwd("ws_fwd", ws_fwd, fwd_of(m_ws, ws_ent));
        check_fwd("ms_fwd", ms_fwd, fwd_of(m_ms, ms_ent));
        if (commit_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_error("an instruction retired while the model had none in flight");
            end
            exp = exp_q.pop_front();
            check_commit("commit", commit, exp);
            if (exp.rf_wen[0] && (exp.rf_wnum != 5'd0)) begin
                srf[exp.rf_wnum] = exp.rf_wdata;
            end
            n_retired++;
        end
        if (accept) begin
            exp_q.push_back(model_accept(es_to_ms_bus));
        end
        m_ws     = ws_allow ? m_ms : m_ws;
        m_ms     = ms_allow ? accept : m_ms;
        accepted = accept;
    endtask

    always @(negedge clk) begin
        monitor_cycle();
    end

    initial begin
        #(watchdog_ns);
        stop_with_error("watchdog expired before all instructions retired");
    end

    initial begin
        logic [4:0] a;
        lfsr           = 32'h4cbe;
        reset          = 1'b1;
        es_to_ms_valid = 1'b0;
        es_to_ms_bus   = '0;
        commit_hold    = 1'b0;
        rf_raddr1      = 5'd0;
        rf_raddr2      = 5'd0;
        m_ms           = 1'b0;
        m_ws           = 1'b0;
        accepted       = 1'b0;
        n_issued       = 0;
        n_retired      = 0;
        next_pc        = 32'h0040_0000;
        for (int i = 0; i < sram_words; i++) begin
            i_mips_tail.u_data_sram.mem[i] = 32'h0; // sram powers up unknown
            smem[i]                        = 32'h0;
        end
        for (int i = 0; i < 32; i++) begin
            srf[i] = 32'h0;
        end
        repeat (5) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        drive_cycle();
        while (n_retired < n_instr) begin
            @(posedge clk);
            #drive_delay;
            drive_cycle();
        end
        es_to_ms_valid = 1'b0;
        commit_hold    = 1'b0;
        // final gpr sweep, port 2 walks downward
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #drive_delay;
            a         = i[4:0];
            rf_raddr1 = a;
            rf_raddr2 = ~a;
            @(negedge clk);
            check_word("rf_rdata1", rf_rdata1, srf[a]);
            check_word("rf_rdata2", rf_rdata2, srf[~a]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== tb/mips_tail_checker.sv ====
module mips_tail_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   ms_valid,
    input logic                   ws_valid,
    input logic                   ms_allowin,
    input logic                   commit_hold,
    input logic                   commit_valid,
    input mips_tail_pkg::commit_t commit,
    input mips_tail_pkg::fwd_t    ws_fwd,
    input logic                   rf_we
);

    timeunit 1ns;
    timeprecision 100ps;

    // retirement only out of a full ws
    commit_needs_ws: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> ws_valid)
        else $error("commit_valid raised with ws empty");

    // an empty ms always takes a new instruction
    empty_ms_allows: assert property (@(posedge clk) disable iff (reset)
        !ms_valid |-> ms_allowin)
        else $error("ms_allowin low with ms empty");

    // ws frozen across consecutive hold cycles
    hold_keeps_ws: assert property (@(posedge clk) disable iff (reset)
        (commit_hold && $past(commit_hold) && $past(ws_valid))
            |-> ($stable(commit) && $stable(ws_fwd)))
        else $error("ws content changed under commit_hold");

    faulting_no_write: assert property (@(posedge clk) disable iff (reset)
        commit.ex |-> !rf_we)
        else $error("register file written by an excepting instruction");

endmodule

bind mips_tail mips_tail_checker i_mips_tail_checker (
    .clk          (clk),
    .reset        (reset),
    .ms_valid     (ms_valid),
    .ws_valid     (ws_valid),
    .ms_allowin   (ms_allowin),
    .commit_hold  (commit_hold),
    .commit_valid (commit_valid),
    .commit       (commit),
    .ws_fwd       (ws_fwd),
    .rf_we        (rf_write.we)
);

// ==== source/mips_tail.sv ====
module mips_tail (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     es_to_ms_valid,
    input  mips_tail_pkg::es_to_ms_t es_to_ms_bus,
    input  logic                     commit_hold,
    input  logic [4:0]               rf_raddr1,
    input  logic [4:0]               rf_raddr2,
    output logic                     ms_allowin,
    output logic                     commit_valid,
    output mips_tail_pkg::commit_t   commit,
    output mips_tail_pkg::fwd_t      ms_fwd,
    output mips_tail_pkg::fwd_t      ws_fwd,
    output logic [31:0]              rf_rdata1,
    output logic [31:0]              rf_rdata2
);

    import mips_tail_pkg::*;

    logic        ms_load;
    logic        ws_load;
    logic        ms_valid;
    logic        ws_valid;
    sram_req_t   sram_req;
    logic [31:0] sram_rdata;
    ms_to_ws_t   ms_to_ws_bus;
    rf_write_t   rf_write;

    // valid bits and handshake
    pipe_ctrl u_pipe_ctrl (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .commit_hold    (commit_hold),
        .ms_allowin     (ms_allowin),
        .ms_load        (ms_load),
        .ws_load        (ws_load),
        .ms_valid       (ms_valid),
        .ws_valid       (ws_valid),
        .commit_valid   (commit_valid)
    );

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .ms_load    (ms_load),
        .ms_valid   (ms_valid),
        .in_bus     (es_to_ms_bus),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata),
        .out_bus    (ms_to_ws_bus),
        .fwd        (ms_fwd)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .req   (sram_req),
        .rdata (sram_rdata)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .reset        (reset),
        .ws_load      (ws_load),
        .ws_valid     (ws_valid),
        .commit_valid (commit_valid),
        .in_bus       (ms_to_ws_bus),
        .rf_write     (rf_write),
        .commit       (commit),
        .fwd          (ws_fwd)
    );

    // read ports go straight out to decode
    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .wr     (rf_write),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

endmodule

// ==== source/reg_file.sv ====
module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  mips_tail_pkg::rf_write_t wr,
    input  logic [4:0]               raddr1,
    input  logic [4:0]               raddr2,
    output logic [31:0]              rdata1,
    output logic [31:0]              rdata2
);

    logic [31:0][31:0] regs;

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (wr.we && (wr.waddr != 5'd0)) begin
            regs[wr.waddr] <= wr.wdata; // r0 never written
        end
    end

    // combinational reads, no write bypass
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

// ==== source/wb_stage.sv ====
`include "mips_tail_defines.svh"

module wb_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ws_load,
    input  logic                     ws_valid,
    input  logic                     commit_valid,
    input  mips_tail_pkg::ms_to_ws_t in_bus,
    output mips_tail_pkg::rf_write_t rf_write,
    output mips_tail_pkg::commit_t   commit,
    output mips_tail_pkg::fwd_t      fwd
);

    import mips_tail_pkg::*;

    ms_to_ws_t bus_r;
    logic      rf_we;

    // trace pc starts from the boot vector
    always_ff @(posedge clk) begin
        if (reset) begin
            bus_r <= '{pc: `MT_RESET_PC, default: '0};
        end else if (ws_load) begin
            bus_r <= in_bus;
        end
    end

    // excepting instructions never write the gprs
    assign rf_we = commit_valid && bus_r.gr_we && !bus_r.ex;

    assign rf_write.we    = rf_we;
    assign rf_write.waddr = bus_r.dest;
    assign rf_write.wdata = bus_r.final_result;

    // trace port, wen replicated per byte
    assign commit.pc       = bus_r.pc;
    assign commit.rf_wen   = {4{rf_we}};
    assign commit.rf_wnum  = bus_r.dest;
    assign commit.rf_wdata = bus_r.final_result;
    assign commit.ex       = bus_r.ex;
    assign commit.excode   = bus_r.excode;

    // held value still forwards under commit_hold
    assign fwd.dest   = (ws_valid && bus_r.gr_we && !bus_r.ex) ? bus_r.dest : 5'd0;
    assign fwd.result = bus_r.final_result;

endmodule

// ==== source/mem_stage.sv ====
`include "mips_tail_defines.svh"

module mem_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ms_load,
    input  logic                     ms_valid,
    input  mips_tail_pkg::es_to_ms_t in_bus,
    output mips_tail_pkg::sram_req_t sram_req,
    input  logic [31:0]              sram_rdata,
    output mips_tail_pkg::ms_to_ws_t out_bus,
    output mips_tail_pkg::fwd_t      fwd
);

    import mips_tail_pkg::*;

    logic        is_load;
    logic        is_store;
    logic        addr_bad;
    logic        adel;
    logic        ades;
    logic [1:0]  lo;
    es_to_ms_t   bus_next;
    logic [31:0] badvaddr_next;

    es_to_ms_t   bus_r;
    logic [31:0] badvaddr_r;
    logic        rd_pend;     // sram rdata lands this cycle
    logic [31:0] rdata_hold;
    logic [31:0] load_word;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] final_result;

    // address check on the incoming instruction
    always_comb begin
        lo       = in_bus.alu_result[1:0];
        is_load  = in_bus.op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
        is_store = in_bus.op inside {mem_sb, mem_sh, mem_sw};
        case (in_bus.op)
            mem_lh, mem_lhu, mem_sh: addr_bad = lo[0];
            mem_lw, mem_sw:          addr_bad = (lo != 2'b00);
            default:                 addr_bad = 1'b0;
        endcase
        // an upstream exception keeps its own code
        adel = is_load && addr_bad && !in_bus.ex;
        ades = is_store && addr_bad && !in_bus.ex;

        bus_next = in_bus;
        if (adel) begin
            bus_next.ex     = 1'b1;
            bus_next.excode = `MT_EXC_ADEL;
        end else if (ades) begin
            bus_next.ex     = 1'b1;
            bus_next.excode = `MT_EXC_ADES;
        end
        badvaddr_next = (adel || ades) ? in_bus.alu_result : 32'b0;
    end

    // sram request, issued in the acceptance cycle
    always_comb begin
        sram_req.en    = ms_load && (is_load || is_store) && !bus_next.ex;
        sram_req.addr  = in_bus.alu_result[`MT_SRAM_AW+1:2];
        sram_req.wen   = 4'b0000;
        sram_req.wdata = in_bus.store_data;
        case (in_bus.op)
            mem_sb: begin
                sram_req.wen   = 4'b0001 << lo;                 // one lane
                sram_req.wdata = {4{in_bus.store_data[7:0]}};  // byte on every lane
            end
            mem_sh: begin
                sram_req.wen   = lo[1] ? 4'b1100 : 4'b0011;
                sram_req.wdata = {2{in_bus.store_data[15:0]}};
            end
            mem_sw: begin
                sram_req.wen = 4'b1111;
            end
            default: begin
                sram_req.wen = 4'b0000; // loads and plain ops
            end
        endcase
        if (!sram_req.en) begin
            sram_req.wen = 4'b0000; // faulting store leaves memory alone
        end
    end

    always_ff @(posedge clk) begin
        if (ms_load) begin
            bus_r      <= bus_next;
            badvaddr_r <= badvaddr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= ms_load;
        end
    end

    // keeps load data while ms is stalled
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            rdata_hold <= sram_rdata;
        end
    end

    assign load_word = rd_pend ? sram_rdata : rdata_hold;

    // lane select and extension
    always_comb begin
        ld_byte = load_word[{bus_r.alu_result[1:0], 3'b000} +: 8];
        ld_half = load_word[{bus_r.alu_result[1], 4'b0000} +: 16];
        case (bus_r.op)
            mem_lb:  final_result = {{24{ld_byte[7]}}, ld_byte};
            mem_lbu: final_result = {24'b0, ld_byte};
            mem_lh:  final_result = {{16{ld_half[15]}}, ld_half};
            mem_lhu: final_result = {16'b0, ld_half};
            mem_lw:  final_result = load_word;
            default: final_result = bus_r.alu_result; // alu ops pass through
        endcase
    end

    assign out_bus.pc           = bus_r.pc;
    assign out_bus.ex           = bus_r.ex;
    assign out_bus.excode       = bus_r.excode;
    assign out_bus.gr_we        = bus_r.gr_we;
    assign out_bus.dest         = bus_r.dest;
    assign out_bus.final_result = final_result;
    assign out_bus.badvaddr     = badvaddr_r;

    // bypass only what will really be written
    assign fwd.dest   = (ms_valid && bus_r.gr_we && !bus_r.ex) ? bus_r.dest : 5'd0;
    assign fwd.result = final_result;

endmodule

// ==== source/data_sram.sv ====
`include "mips_tail_defines.svh"

module data_sram (
    input  logic                     clk,
    input  mips_tail_pkg::sram_req_t req,
    output logic [31:0]              rdata
);

    localparam int depth = 1 << `MT_SRAM_AW;

    logic [31:0] mem [0:depth-1]; // no reset, contents undefined at power up

    // byte lane writes
    always_ff @(posedge clk) begin
        if (req.en) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wen[i]) begin
                    mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-cycle write
    // rdata holds while en is low
    always_ff @(posedge clk) begin
        if (req.en) begin
            rdata <= mem[req.addr];
        end
    end

endmodule

// ==== source/pipe_ctrl.sv ====
module pipe_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic es_to_ms_valid,
    input  logic commit_hold,
    output logic ms_allowin,
    output logic ms_load,
    output logic ws_load,
    output logic ms_valid,
    output logic ws_valid,
    output logic commit_valid
);

    logic ms_ready_go;
    logic ms_to_ws_valid;
    logic ws_ready_go;
    logic ws_allowin;

    // ready_go / allowin chain, back to front
    assign ws_ready_go = !commit_hold;              // retirement stalls on hold
    assign ws_allowin  = !ws_valid || ws_ready_go;
    assign ms_ready_go = 1'b1;                      // sram read is fixed latency
    assign ms_allowin  = !ms_valid || (ms_ready_go && ws_allowin);

    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    // load enables for the datapath registers
    assign ms_load = es_to_ms_valid && ms_allowin;
    assign ws_load = ms_to_ws_valid && ws_allowin;

    assign commit_valid = ws_valid && ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid; // drains when execute has nothing
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

endmodule

// ==== source/mips_tail_pkg.sv ====
`include "mips_tail_defines.svh"

package mips_tail_pkg;

    // memory access kind carried down from execute
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lbu  = 4'd2,
        mem_lh   = 4'd3,
        mem_lhu  = 4'd4,
        mem_lw   = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_t;

    // execute to memory stage
    typedef struct packed {
        logic [31:0] pc;
        mem_op_t     op;
        logic        gr_we;      // writes a gpr
        logic [4:0]  dest;
        logic [31:0] alu_result; // address for loads and stores
        logic [31:0] store_data; // rt value, unshifted
        logic        ex;
        logic [4:0]  excode;
    } es_to_ms_t;

    // memory stage to write-back
    typedef struct packed {
        logic [31:0] pc;
        logic        ex;
        logic [4:0]  excode;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] final_result;
        logic [31:0] badvaddr; // faulting address on adel / ades
    } ms_to_ws_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_write_t;

    // bypass value for decode, dest of zero means nothing to forward
    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] result;
    } fwd_t;

    // retirement trace
    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rf_wen;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
        logic        ex;
        logic [4:0]  excode;
    } commit_t;

    typedef struct packed {
        logic                   en;
        logic [3:0]             wen;  // byte lanes, zero for a read
        logic [`MT_SRAM_AW-1:0] addr; // word address
        logic [31:0]            wdata;
    } sram_req_t;

endpackage

// ==== source/mips_tail_defines.svh ====
`ifndef MIPS_TAIL_DEFINES_SVH
`define MIPS_TAIL_DEFINES_SVH

// word address width of the data sram
`define MT_SRAM_AW 10

// cp0 cause codes for address errors
`define MT_EXC_ADEL 5'd4 // load side
`define MT_EXC_ADES 5'd5 // store side

// pc shown on the trace port before the first retirement
`define MT_RESET_PC 32'hbfc0_0000

`endif
